/* logic/usb_pkg.sv */
package usb_pkg;

  // Modelled USB line states, coded as the ULPI LineState field
  typedef enum logic [1:0] {
    LINE_SE0 = 2'b00,
    LINE_J   = 2'b01,
    LINE_K   = 2'b10
  } usb_linestate_e;

  // Width of the PID field in a token or handshake byte
  localparam int PID_WIDTH = 4;

  // Cycles of SE0 after a transmitted packet ends
  localparam logic [1:0] SE0_HOLD_CYCLES = 2'd2;

  // Period of the status timer, a short stand-in for 2.5 us
  localparam logic [3:0] STATUS_INTERVAL = 4'd12;

endpackage

/* logic/ulpi_pkg.sv */
package ulpi_pkg;

  // Command opcode in bits 7:6 of a link command byte
  typedef enum logic [1:0] {
    CMD_SPECIAL   = 2'b00,
    CMD_TRANSMIT  = 2'b01,
    CMD_REG_WRITE = 2'b10,
    CMD_REG_READ  = 2'b11
  } ulpi_cmd_e;

  // Transmit command with a zero PID starts a K-chirp
  localparam logic [7:0] NOPID = 8'h40;

  // RX CMD fields
  localparam logic [1:0] RXEVENT_NONE     = 2'b00;
  localparam logic [1:0] RXEVENT_ACTIVE   = 2'b01;
  localparam logic [1:0] RXCMD_VBUS_VALID = 2'b11;
  localparam logic [1:0] RXCMD_TAG        = 2'b01;

  // Register map
  localparam logic [5:0] REG_VENDOR_ID  = 6'h00;
  localparam logic [5:0] REG_FUNC_CTRL  = 6'h04;
  localparam logic [5:0] REG_IFACE_CTRL = 6'h07;
  localparam logic [5:0] REG_SCRATCH    = 6'h16;

  localparam logic [7:0] VENDOR_ID_VALUE = 8'h24;
  localparam logic [7:0] FUNC_CTRL_RESET = 8'h41;

  typedef enum logic [3:0] {
    ST_IDLE, ST_TX_WAIT, ST_TX_DATA, ST_RX_TURN, ST_RX_CMD,
    ST_RX_DATA, ST_REG_WRITE, ST_REG_TURN, ST_REG_DATA, ST_CHIRP
  } engine_state_e;

  typedef enum logic [1:0] {
    STATUS_OFF, STATUS_TURN, STATUS_CMD
  } status_state_e;

  // Build an RX CMD byte from the event code and the line state
  function automatic logic [7:0] rx_cmd_byte(input logic [1:0] rx_event,
                                             input logic [1:0] line_state);
    return {RXCMD_TAG, rx_event, RXCMD_VBUS_VALID, line_state};
  endfunction

endpackage

/* logic/ulpi_linestate_monitor.sv */
`timescale 1ns/100ps

module ulpi_linestate_monitor
  import usb_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic           chirp_i,
  input  logic           eop_i,
  input  logic           status_grant_i,
  output usb_linestate_e linestate_o,
  output logic           status_req_o
);

  usb_linestate_e line_state;
  usb_linestate_e prev_q;
  usb_linestate_e reported_q;
  usb_linestate_e report_q;
  logic [$bits(SE0_HOLD_CYCLES)-1:0] se0_count_q;
  logic [$bits(STATUS_INTERVAL)-1:0] timer_q;
  logic timer_pulse;
  logic sample;
  logic capture;

  // Chirp wins over the SE0 that follows a packet
  always_comb begin
    if (chirp_i) begin
      line_state = LINE_K;
    end else if (se0_count_q != '0) begin
      line_state = LINE_SE0;
    end else begin
      line_state = LINE_J;
    end
  end

  assign timer_pulse = timer_q == STATUS_INTERVAL - 4'd1;

  // A fresh change is sampled at once so short SE0 is not missed
  assign sample  = timer_pulse || (line_state != prev_q);
  assign capture = sample && !status_req_o && (line_state != reported_q);

  // While a report is pending the arbiter sees the captured state
  assign linestate_o = status_req_o ? report_q : line_state;

  always_ff @(posedge clock) begin
    if (reset) begin
      se0_count_q  <= '0;
      timer_q      <= '0;
      prev_q       <= LINE_J;
      reported_q   <= LINE_J;
      status_req_o <= 1'b0;
    end else begin
      prev_q  <= line_state;
      timer_q <= timer_pulse ? '0 : timer_q + 1'b1;

      if (eop_i) begin
        se0_count_q <= SE0_HOLD_CYCLES;
      end else if (se0_count_q != '0) begin
        se0_count_q <= se0_count_q - 1'b1;
      end

      if (status_grant_i) begin
        status_req_o <= 1'b0;
        reported_q   <= report_q;
      end else if (capture) begin
        status_req_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      report_q <= line_state;
    end
  end

endmodule

/* logic/ulpi_transfer_engine.sv */
`timescale 1ns/100ps

module ulpi_transfer_engine
  import usb_pkg::*;
  import ulpi_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic [7:0]     ulpi_data_i,
  input  logic           ulpi_stp_i,
  input  logic           bus_held_i,
  input  usb_linestate_e linestate_i,
  input  logic           usb_in_valid_i,
  input  logic           usb_in_last_i,
  input  logic [7:0]     usb_in_data_i,
  input  logic           usb_out_ready_i,
  output logic           eng_dir_o,
  output logic           eng_nxt_o,
  output logic [7:0]     eng_data_o,
  output logic           eng_idle_o,
  output logic           chirp_o,
  output logic           eop_o,
  output logic           usb_in_ready_o,
  output logic           usb_out_valid_o,
  output logic           usb_out_last_o,
  output logic [7:0]     usb_out_data_o
);

  engine_state_e state;
  ulpi_cmd_e     cmd;
  logic          nxt_q;
  logic          read_q;
  logic          drain_q;
  logic [5:0]    addr_q;
  logic [7:0]    wdata_q;
  logic [7:0]    func_ctrl_q;
  logic [7:0]    iface_ctrl_q;
  logic [7:0]    scratch_q;
  logic [7:0]    read_data;
  logic          can_start;
  logic          cmd_seen;
  logic          in_fire;
  logic          tx_accept;
  logic [7:0]    tx_byte;
  logic          out_free;
  logic          out_valid_q;
  logic          out_last_q;
  logic [7:0]    out_data_q;
  logic          skid_valid_q;
  logic          skid_last_q;
  logic [7:0]    skid_data_q;

  assign cmd      = ulpi_cmd_e'(ulpi_data_i[7:6]);
  assign cmd_seen = ulpi_data_i != 8'h00;
  assign in_fire  = usb_in_valid_i && usb_in_ready_o;

  // Nothing new starts until the out stream and any aborted packet have drained
  assign can_start  = (state == ST_IDLE) && !bus_held_i && !drain_q &&
                      !out_valid_q && !skid_valid_q;
  assign eng_idle_o = can_start && !cmd_seen && !usb_in_valid_i;

  // PID byte goes out as inverted PID over PID
  assign tx_accept = (state == ST_TX_WAIT || state == ST_TX_DATA) && nxt_q && !ulpi_stp_i;
  assign tx_byte   = (state == ST_TX_WAIT) ?
                     {~ulpi_data_i[PID_WIDTH-1:0], ulpi_data_i[PID_WIDTH-1:0]} : ulpi_data_i;
  assign out_free  = !out_valid_q || usb_out_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= ST_IDLE;
      nxt_q        <= 1'b0;
      read_q       <= 1'b0;
      drain_q      <= 1'b0;
      func_ctrl_q  <= FUNC_CTRL_RESET;
      iface_ctrl_q <= 8'h00;
      scratch_q    <= 8'h00;
    end else begin
      if (drain_q && in_fire && usb_in_last_i) begin
        drain_q <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (can_start && cmd_seen) begin
            case (cmd)
              CMD_TRANSMIT: begin
                if (ulpi_data_i == NOPID) begin
                  state <= ST_CHIRP;
                  nxt_q <= 1'b1;
                end else begin
                  state <= ST_TX_WAIT;
                  nxt_q <= usb_out_ready_i;
                end
              end
              CMD_REG_WRITE, CMD_REG_READ: begin
                state  <= ST_REG_WRITE;
                read_q <= cmd == CMD_REG_READ;
                nxt_q  <= 1'b1;
              end
              // Special commands are not modelled
              default: state <= ST_IDLE;
            endcase
          end else if (can_start && usb_in_valid_i) begin
            state <= ST_RX_TURN;
          end
        end
        ST_TX_WAIT: begin
          nxt_q <= usb_out_ready_i;
          if (nxt_q) begin
            state <= ST_TX_DATA;
          end
        end
        ST_TX_DATA: begin
          nxt_q <= usb_out_ready_i && !ulpi_stp_i;
          if (ulpi_stp_i) begin
            state <= ST_IDLE;
          end
        end
        ST_RX_TURN, ST_RX_CMD: begin
          drain_q <= ulpi_stp_i;
          if (ulpi_stp_i) begin
            state <= ST_IDLE;
          end else begin
            state <= (state == ST_RX_TURN) ? ST_RX_CMD : ST_RX_DATA;
          end
        end
        ST_RX_DATA: begin
          if (ulpi_stp_i) begin
            state   <= ST_IDLE;
            drain_q <= !(in_fire && usb_in_last_i);
          end else if (in_fire && usb_in_last_i) begin
            state <= ST_IDLE;
          end
        end
        // Register command accepted; a read leaves after one nxt cycle
        ST_REG_WRITE: begin
          if (read_q) begin
            state <= ST_REG_TURN;
            nxt_q <= 1'b0;
          end else if (ulpi_stp_i) begin
            state <= ST_IDLE;
            nxt_q <= 1'b0;
            case (addr_q)
              REG_FUNC_CTRL:  func_ctrl_q  <= wdata_q;
              REG_IFACE_CTRL: iface_ctrl_q <= wdata_q;
              REG_SCRATCH:    scratch_q    <= wdata_q;
              default:        scratch_q    <= scratch_q;
            endcase
          end
        end
        ST_REG_TURN: state <= ST_REG_DATA;
        ST_CHIRP: begin
          if (ulpi_stp_i) begin
            state <= ST_IDLE;
            nxt_q <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Out stream with one output stage plus a skid entry for the byte in flight
  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_q  <= 1'b0;
      out_last_q   <= 1'b0;
      skid_valid_q <= 1'b0;
      skid_last_q  <= 1'b0;
    end else if (out_free) begin
      out_valid_q  <= skid_valid_q || tx_accept;
      out_last_q   <= skid_valid_q && (skid_last_q || eop_o);
      skid_valid_q <= 1'b0;
      skid_last_q  <= 1'b0;
    end else begin
      out_last_q  <= out_last_q || (eop_o && !skid_valid_q);
      skid_last_q <= skid_valid_q && (skid_last_q || eop_o);
      if (tx_accept) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    wdata_q <= ulpi_data_i;
    if (state == ST_IDLE) begin
      addr_q <= ulpi_data_i[5:0];
    end
    if (out_free) begin
      out_data_q <= skid_valid_q ? skid_data_q : tx_byte;
    end else if (tx_accept) begin
      skid_data_q <= tx_byte;
    end
  end

  always_comb begin
    case (addr_q)
      REG_VENDOR_ID:  read_data = VENDOR_ID_VALUE;
      REG_FUNC_CTRL:  read_data = func_ctrl_q;
      REG_IFACE_CTRL: read_data = iface_ctrl_q;
      REG_SCRATCH:    read_data = scratch_q;
      default:        read_data = 8'h00;
    endcase
  end

  always_comb begin
    case (state)
      ST_RX_CMD:   eng_data_o = rx_cmd_byte(RXEVENT_ACTIVE, linestate_i);
      ST_RX_DATA:  eng_data_o = usb_in_data_i;
      ST_REG_DATA: eng_data_o = read_data;
      default:     eng_data_o = 8'h00;
    endcase
  end

  assign eng_dir_o = state inside {ST_RX_TURN, ST_RX_CMD, ST_RX_DATA, ST_REG_TURN, ST_REG_DATA};
  // Receive data paces nxt directly from the incoming stream
  assign eng_nxt_o = (state == ST_RX_DATA) ? usb_in_valid_i : nxt_q;

  assign chirp_o        = state == ST_CHIRP;
  assign eop_o          = (state == ST_TX_DATA) && ulpi_stp_i;
  assign usb_in_ready_o = (state == ST_RX_DATA) || drain_q;

  assign usb_out_valid_o = out_valid_q;
  assign usb_out_last_o  = out_last_q || (eop_o && !skid_valid_q);
  assign usb_out_data_o  = out_data_q;

endmodule

/* logic/ulpi_bus_arbiter.sv */
`timescale 1ns/100ps

module ulpi_bus_arbiter
  import usb_pkg::*;
  import ulpi_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic           eng_dir_i,
  input  logic           eng_nxt_i,
  input  logic [7:0]     eng_data_i,
  input  logic           eng_idle_i,
  input  logic           status_req_i,
  input  usb_linestate_e linestate_i,
  output logic           status_grant_o,
  output logic           bus_held_o,
  output logic           ulpi_dir_o,
  output logic           ulpi_nxt_o,
  output logic [7:0]     ulpi_data_o
);

  status_state_e  state;
  usb_linestate_e report_q;

  // Status only slips in between engine transfers
  assign status_grant_o = (state == STATUS_OFF) && status_req_i && eng_idle_i;
  assign bus_held_o     = state != STATUS_OFF;

  assign ulpi_dir_o  = bus_held_o || eng_dir_i;
  assign ulpi_nxt_o  = !bus_held_o && eng_nxt_i;
  assign ulpi_data_o = (state == STATUS_CMD) ? rx_cmd_byte(RXEVENT_NONE, report_q) : eng_data_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= STATUS_OFF;
    end else begin
      case (state)
        STATUS_OFF: begin
          if (status_grant_o) begin
            state <= STATUS_TURN;
          end
        end
        STATUS_TURN: state <= STATUS_CMD;
        default:     state <= STATUS_OFF;
      endcase
    end
  end

  // Line state is frozen at the grant for the RX CMD two cycles later
  always_ff @(posedge clock) begin
    if (status_grant_o) begin
      report_q <= linestate_i;
    end
  end

endmodule

/* logic/fake_ulpi_phy.sv */
`timescale 1ns/100ps

module fake_ulpi_phy
  import usb_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  logic [7:0] ulpi_data_i,
  input  logic       ulpi_stp_i,
  output logic       ulpi_dir_o,
  output logic       ulpi_nxt_o,
  output logic [7:0] ulpi_data_o,

  // Packets from the USB line toward the link
  input  logic       usb_in_valid_i,
  output logic       usb_in_ready_o,
  input  logic       usb_in_last_i,
  input  logic [7:0] usb_in_data_i,

  // Packets transmitted by the link
  output logic       usb_out_valid_o,
  input  logic       usb_out_ready_i,
  output logic       usb_out_last_o,
  output logic [7:0] usb_out_data_o
);

  logic           eng_dir;
  logic           eng_nxt;
  logic [7:0]     eng_data;
  logic           eng_idle;
  logic           chirp;
  logic           eop;
  logic           status_req;
  logic           status_grant;
  logic           bus_held;
  usb_linestate_e linestate;

  ulpi_linestate_monitor monitor0 (
    .clock          (clock),
    .reset          (reset),
    .chirp_i        (chirp),
    .eop_i          (eop),
    .status_grant_i (status_grant),
    .linestate_o    (linestate),
    .status_req_o   (status_req)
  );

  ulpi_transfer_engine engine0 (
    .clock           (clock),
    .reset           (reset),
    .ulpi_data_i     (ulpi_data_i),
    .ulpi_stp_i      (ulpi_stp_i),
    .bus_held_i      (bus_held),
    .linestate_i     (linestate),
    .usb_in_valid_i  (usb_in_valid_i),
    .usb_in_last_i   (usb_in_last_i),
    .usb_in_data_i   (usb_in_data_i),
    .usb_out_ready_i (usb_out_ready_i),
    .eng_dir_o       (eng_dir),
    .eng_nxt_o       (eng_nxt),
    .eng_data_o      (eng_data),
    .eng_idle_o      (eng_idle),
    .chirp_o         (chirp),
    .eop_o           (eop),
    .usb_in_ready_o  (usb_in_ready_o),
    .usb_out_valid_o (usb_out_valid_o),
    .usb_out_last_o  (usb_out_last_o),
    .usb_out_data_o  (usb_out_data_o)
  );

  ulpi_bus_arbiter arbiter0 (
    .clock          (clock),
    .reset          (reset),
    .eng_dir_i      (eng_dir),
    .eng_nxt_i      (eng_nxt),
    .eng_data_i     (eng_data),
    .eng_idle_i     (eng_idle),
    .status_req_i   (status_req),
    .linestate_i    (linestate),
    .status_grant_o (status_grant),
    .bus_held_o     (bus_held),
    .ulpi_dir_o     (ulpi_dir_o),
    .ulpi_nxt_o     (ulpi_nxt_o),
    .ulpi_data_o    (ulpi_data_o)
  );

endmodule

/* bench/fake_ulpi_phy_props.sv */
`timescale 1ns/100ps

module fake_ulpi_phy_props (
  input logic clock,
  input logic reset,
  input logic ulpi_dir_o,
  input logic ulpi_nxt_o,
  input logic usb_out_valid_o
);

  // Reset needs one edge to reach the registers
  reset_quiet: assert property (@(posedge clock)
    reset && $past(reset) |-> !ulpi_dir_o && !ulpi_nxt_o)
    else $error("dir or nxt high during reset");

  // Link-bound packets never overlap a PHY-driven bus
  out_while_dir: assert property (@(posedge clock) disable iff (reset)
    usb_out_valid_o |-> !ulpi_dir_o)
    else $error("out stream valid while dir is high");

  // One turnaround cycle with nxt low, then dir stays high
  turnaround: assert property (@(posedge clock) disable iff (reset)
    $rose(ulpi_dir_o) |-> !ulpi_nxt_o ##1 ulpi_dir_o)
    else $error("dir rise without a single quiet turnaround cycle");

endmodule

bind fake_ulpi_phy fake_ulpi_phy_props props0 (.*);

/* bench/fake_ulpi_phy_tb.sv */
`timescale 1ns/100ps

module fake_ulpi_phy_tb
  import usb_pkg::*;
  import ulpi_pkg::*;
();

  localparam int OP_IDLE  = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_READ  = 2;
  localparam int OP_TX    = 3;
  localparam int OP_RX    = 4;
  localparam int OP_CHIRP = 5;
  localparam int NUM_OPS  = 11;

  // Wait conditions
  localparam int W_NXT     = 0;
  localparam int W_DIR     = 1;
  localparam int W_DIR_LOW = 2;
  localparam int W_IN_FIRE = 3;
  localparam int W_RXCMD   = 4;
  localparam int W_OUT     = 5;

  typedef struct {
    int         kind;
    logic [7:0] field;
    int         count;
    logic [7:0] ready;
    logic [7:0] value;
  } op_t;

  logic       clock;
  logic       reset;
  logic [7:0] ulpi_data_i;
  logic       ulpi_stp_i;
  logic       ulpi_dir_o;
  logic       ulpi_nxt_o;
  logic [7:0] ulpi_data_o;
  logic       usb_in_valid_i;
  logic       usb_in_ready_o;
  logic       usb_in_last_i;
  logic [7:0] usb_in_data_i;
  logic       usb_out_valid_o;
  logic       usb_out_ready_i = 1'b1;
  logic       usb_out_last_o;
  logic [7:0] usb_out_data_o;

  op_t        ops [NUM_OPS];
  logic [7:0] ready_pat = 8'hff;
  logic [2:0] ready_phase = 3'd0;
  bit         reading = 1'b0;
  int         dir_cycles = 0;
  int         error_count = 0;
  int         check_count = 0;
  logic [31:0] rand_state = 32'h96b0569e;
  logic [7:0] payload [$];
  logic [7:0] rxcmd_q [$];
  logic [7:0] rx_data_q [$];
  logic [7:0] out_data_q [$];
  logic       out_last_q [$];

  fake_ulpi_phy dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Out-stream ready follows the current 8-cycle pattern
  always @(posedge clock) begin
    usb_out_ready_i <= ready_pat[ready_phase];
    ready_phase     <= ready_phase + 1'b1;
  end

  // Bus and stream observer
  always @(negedge clock) begin
    if (!reset) begin
      dir_cycles = ulpi_dir_o ? dir_cycles + 1 : 0;
      // Second dir cycle is an RX CMD unless a register read owns it
      if (dir_cycles == 2 && !reading) begin
        rxcmd_q.push_back(ulpi_data_o);
      end
      if (dir_cycles >= 3 && ulpi_nxt_o) begin
        rx_data_q.push_back(ulpi_data_o);
      end
      if (usb_out_valid_o && usb_out_ready_i) begin
        out_data_q.push_back(usb_out_data_o);
        out_last_q.push_back(usb_out_last_o);
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void make_payload(input int n);
    payload.delete();
    for (int i = 0; i < n; i++) begin
      rand_state = xorshift(rand_state);
      payload.push_back(rand_state[7:0]);
    end
  endfunction

  function automatic void load_table();
    ops[0]  = '{OP_IDLE,  8'h00,               0, 8'hff, 8'h00};
    ops[1]  = '{OP_WRITE, {2'b00, REG_SCRATCH},   0, 8'hff, 8'h5a};
    ops[2]  = '{OP_WRITE, {2'b00, REG_FUNC_CTRL}, 0, 8'hff, 8'h29};
    ops[3]  = '{OP_READ,  {2'b00, REG_SCRATCH},   0, 8'hff, 8'h5a};
    ops[4]  = '{OP_READ,  {2'b00, REG_FUNC_CTRL}, 0, 8'hff, 8'h29};
    ops[5]  = '{OP_READ,  {2'b00, REG_VENDOR_ID}, 0, 8'hff, VENDOR_ID_VALUE};
    ops[6]  = '{OP_READ,  8'h3f,               0, 8'hff, 8'h00};
    ops[7]  = '{OP_TX,    8'h03,               5, 8'hff, 8'h00};
    ops[8]  = '{OP_RX,    8'h00,               6, 8'hff, 8'h00};
    ops[9]  = '{OP_CHIRP, 8'h00,               0, 8'hff, 8'h00};
    ops[10] = '{OP_TX,    8'h0b,               7, 8'b10110010, 8'h00};
  endfunction

  function automatic string op_name(input int kind);
    case (kind)
      OP_IDLE:  return "idle after reset";
      OP_WRITE: return "register write";
      OP_READ:  return "register read";
      OP_TX:    return "transmit";
      OP_RX:    return "receive";
      default:  return "chirp";
    endcase
  endfunction

  function automatic logic condition_met(input int what, input int count);
    case (what)
      W_NXT:     return ulpi_nxt_o;
      W_DIR:     return ulpi_dir_o;
      W_DIR_LOW: return !ulpi_dir_o;
      W_IN_FIRE: return usb_in_valid_i && usb_in_ready_o;
      W_RXCMD:   return rxcmd_q.size() >= count;
      W_OUT:     return out_data_q.size() >= count;
      default:   return 1'b0;
    endcase
  endfunction

  // Polls just after each falling edge, up to limit cycles
  task automatic wait_until(input int what, input int count, input int limit,
                            input string why);
    int n;
    n = 0;
    @(negedge clock);
    #1;
    while (!condition_met(what, count)) begin
      n++;
      if (n >= limit) begin
        $display("Timed out after %0d cycles waiting for %s", limit, why);
        $display("Some tests failed");
        $finish;
      end
      @(negedge clock);
      #1;
    end
  endtask

  task automatic compare_byte(input string what, input logic [7:0] got,
                              input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got 8'h%02h, expected 8'h%02h", $time, what, got, exp);
    end
  endtask

  task automatic compare_linestate(input string what, input usb_linestate_e got,
                                   input usb_linestate_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got line state %s, expected %s",
               $time, what, got.name(), exp.name());
    end
  endtask

  // Tag 01, VBUS valid 11, then the event and line state fields
  task automatic compare_rx_cmd(input string what, input logic [7:0] got,
                                input logic [1:0] exp_event, input usb_linestate_e exp_line);
    check_count++;
    if (got[7:2] !== {2'b01, exp_event, 2'b11}) begin
      error_count++;
      $display("error at %0t: %s got RX CMD 8'h%02h, expected event %b with fixed bits",
               $time, what, got, exp_event);
    end
    compare_linestate({what, " line state"}, usb_linestate_e'(got[1:0]), exp_line);
  endtask

  task automatic send_command(input logic [7:0] cmd);
    wait_until(W_DIR_LOW, 0, 100, "dir low before a command byte");
    @(posedge clock);
    ulpi_data_i <= cmd;
    wait_until(W_NXT, 0, 100, "nxt after a command byte");
  endtask

  task automatic end_transfer();
    @(posedge clock);
    ulpi_data_i <= 8'h00;
    ulpi_stp_i  <= 1'b1;
    @(posedge clock);
    ulpi_stp_i  <= 1'b0;
  endtask

  task automatic check_idle();
    repeat (3 * int'(STATUS_INTERVAL)) begin
      @(negedge clock);
      compare_byte("dir, nxt and out valid", {ulpi_dir_o, ulpi_nxt_o, usb_out_valid_o}, 8'h00);
    end
    compare_byte("RX CMD count", rxcmd_q.size(), 8'd0);
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [7:0] value);
    send_command({CMD_REG_WRITE, addr});
    @(posedge clock);
    ulpi_data_i <= value;
    end_transfer();
  endtask

  task automatic read_reg(input logic [5:0] addr, input logic [7:0] exp);
    send_command({CMD_REG_READ, addr});
    @(posedge clock);
    ulpi_data_i <= 8'h00;
    reading = 1'b1;
    wait_until(W_DIR, 0, 10, "turnaround of a register read");
    @(negedge clock);
    compare_byte("register read dir", ulpi_dir_o, 8'd1);
    compare_byte("register read data", ulpi_data_o, exp);
    wait_until(W_DIR_LOW, 0, 1, "dir to fall after the register data");
    reading = 1'b0;
  endtask

  // Two status RX CMDs in order, both with RxEvent zero
  task automatic expect_status_pair(input usb_linestate_e first, input usb_linestate_e second);
    logic [7:0] b;
    wait_until(W_RXCMD, 2, 100, "two status RX CMDs");
    b = rxcmd_q.pop_front();
    compare_rx_cmd("first status RX CMD", b, RXEVENT_NONE, first);
    b = rxcmd_q.pop_front();
    compare_rx_cmd("second status RX CMD", b, RXEVENT_NONE, second);
  endtask

  task automatic transmit(input logic [3:0] pid, input int n, input logic [7:0] pattern);
    @(negedge clock);
    ready_pat = pattern;
    make_payload(n);
    out_data_q.delete();
    out_last_q.delete();
    send_command({CMD_TRANSMIT, 2'b00, pid});
    for (int i = 0; i < n; i++) begin
      @(posedge clock);
      ulpi_data_i <= payload[i];
      wait_until(W_NXT, 0, 100, "nxt on a transmit payload byte");
    end
    end_transfer();
    wait_until(W_OUT, n + 1, 200, "all transmit bytes on the out stream");
    compare_byte("coded PID byte", out_data_q[0], {~pid, pid});
    for (int i = 0; i <= n; i++) begin
      if (i > 0) begin
        compare_byte("out payload byte", out_data_q[i], payload[i - 1]);
      end
      compare_byte("out last flag", out_last_q[i], i == n);
    end
    expect_status_pair(LINE_SE0, LINE_J);
    // Status is only granted once the out stream has drained
    compare_byte("out byte count", out_data_q.size(), n + 1);
    @(negedge clock);
    ready_pat = 8'hff;
  endtask

  task automatic receive(input int n);
    logic [7:0] b;
    make_payload(n);
    rx_data_q.delete();
    @(posedge clock);
    usb_in_valid_i <= 1'b1;
    usb_in_data_i  <= payload[0];
    usb_in_last_i  <= n == 1;
    for (int i = 0; i < n; i++) begin
      wait_until(W_IN_FIRE, 0, 100, "the PHY to take a receive byte");
      @(posedge clock);
      if (i + 1 < n) begin
        usb_in_data_i <= payload[i + 1];
        usb_in_last_i <= i + 2 == n;
      end else begin
        usb_in_valid_i <= 1'b0;
        usb_in_last_i  <= 1'b0;
      end
    end
    wait_until(W_DIR_LOW, 0, 1, "dir to fall right after the last receive byte");
    wait_until(W_RXCMD, 1, 10, "the receive RX CMD");
    b = rxcmd_q.pop_front();
    compare_rx_cmd("receive RX CMD", b, RXEVENT_ACTIVE, LINE_J);
    compare_byte("receive byte count", rx_data_q.size(), n);
    for (int i = 0; i < n && i < rx_data_q.size(); i++) begin
      compare_byte("receive payload byte", rx_data_q[i], payload[i]);
    end
  endtask

  task automatic chirp();
    send_command(NOPID);
    end_transfer();
    expect_status_pair(LINE_K, LINE_J);
  endtask

  initial begin
    int errors_before;
    reset          <= 1'b1;
    ulpi_data_i    <= 8'h00;
    ulpi_stp_i     <= 1'b0;
    usb_in_valid_i <= 1'b0;
    usb_in_last_i  <= 1'b0;
    usb_in_data_i  <= 8'h00;
    load_table();
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < NUM_OPS; i++) begin
      errors_before = error_count;
      case (ops[i].kind)
        OP_IDLE:  check_idle();
        OP_WRITE: write_reg(ops[i].field[5:0], ops[i].value);
        OP_READ:  read_reg(ops[i].field[5:0], ops[i].value);
        OP_TX:    transmit(ops[i].field[3:0], ops[i].count, ops[i].ready);
        OP_RX:    receive(ops[i].count);
        default:  chirp();
      endcase
      if (error_count == errors_before) begin
        $display("test %0d %s: ok", i, op_name(ops[i].kind));
      end else begin
        $display("test %0d %s: %0d errors", i, op_name(ops[i].kind),
                 error_count - errors_before);
      end
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_OPS, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
logic/usb_pkg.sv
logic/ulpi_pkg.sv
logic/ulpi_linestate_monitor.sv
logic/ulpi_transfer_engine.sv
logic/ulpi_bus_arbiter.sv
logic/fake_ulpi_phy.sv
bench/fake_ulpi_phy_props.sv
bench/fake_ulpi_phy_tb.sv
